//--- source/rv_isa_pkg.sv
package rv_isa_pkg;

  // Data path width and register index width
  localparam int XLEN       = 64;
  localparam int REG_ADDR_W = 5;

  // Major opcodes handled by the back end
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111
  } opcode_e;

  // funct7 selectors
  localparam logic [6:0] FUNCT7_BASE   = 7'b0000000;
  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;
  localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;

  // funct3 values of OP and OP-IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // MUL shares funct3 with ADD
  localparam logic [2:0] F3_MUL     = 3'b000;

endpackage

//--- source/backend_pkg.sv
package backend_pkg;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU
  } alu_op_e;

  // Result select of an execute stage
  typedef enum logic {
    FU_ALU,
    FU_MUL
  } func_unit_e;

  typedef struct packed {
    logic [rv_isa_pkg::XLEN-1:0] pc;
    logic [31:0]                 instr_word;
  } fetch_t;

  typedef struct packed {
    logic [rv_isa_pkg::XLEN-1:0]       pc;
    func_unit_e                        unit;
    alu_op_e                           alu_op;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rd;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2;
    logic                              use_imm;
    logic [rv_isa_pkg::XLEN-1:0]       imm;
    logic                              illegal;
  } decoded_t;

  // What a stage reports to the hazard logic
  typedef struct packed {
    logic                              pending;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rd;
    logic                              data_valid;
    logic [rv_isa_pkg::XLEN-1:0]       data;
  } stage_status_t;

  typedef struct packed {
    logic                              valid;
    logic [rv_isa_pkg::XLEN-1:0]       pc;
    logic [rv_isa_pkg::REG_ADDR_W-1:0] rd;
    logic [rv_isa_pkg::XLEN-1:0]       data;
    logic                              illegal;
  } commit_t;

endpackage

//--- source/decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  fetch_valid_i,
  output logic                                  fetch_ready_o,
  input  backend_pkg::fetch_t                   fetch_instr_i,
  input  logic                                  de_ready_i,
  output logic                                  de_valid_o,
  output backend_pkg::decoded_t                 de_instr_o,
  output logic [rv_isa_pkg::REG_ADDR_W-1:0]     rs1_addr_o,
  output logic [rv_isa_pkg::REG_ADDR_W-1:0]     rs2_addr_o
);

  logic [31:0]           instr;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  backend_pkg::decoded_t decoded;
  logic                  init_done_q;
  logic                  de_valid_q;
  backend_pkg::decoded_t de_instr_q;

  function automatic backend_pkg::alu_op_e alu_op_of(input logic [2:0] f3, input logic alt);
    case (f3)
      rv_isa_pkg::F3_ADD_SUB: alu_op_of = alt ? backend_pkg::ALU_SUB : backend_pkg::ALU_ADD;
      rv_isa_pkg::F3_SLL:     alu_op_of = backend_pkg::ALU_SLL;
      rv_isa_pkg::F3_SLT:     alu_op_of = backend_pkg::ALU_SLT;
      rv_isa_pkg::F3_SLTU:    alu_op_of = backend_pkg::ALU_SLTU;
      rv_isa_pkg::F3_XOR:     alu_op_of = backend_pkg::ALU_XOR;
      rv_isa_pkg::F3_SRL_SRA: alu_op_of = alt ? backend_pkg::ALU_SRA : backend_pkg::ALU_SRL;
      rv_isa_pkg::F3_OR:      alu_op_of = backend_pkg::ALU_OR;
      default:                alu_op_of = backend_pkg::ALU_AND;
    endcase
  endfunction

  assign instr  = fetch_instr_i.instr_word;
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  always_comb begin
    decoded.pc      = fetch_instr_i.pc;
    decoded.unit    = backend_pkg::FU_ALU;
    decoded.alu_op  = alu_op_of(funct3, instr[30]);
    decoded.rd      = instr[11:7];
    decoded.rs1     = instr[19:15];
    decoded.rs2     = instr[24:20];
    decoded.use_imm = 1'b0;
    decoded.imm     = {{(rv_isa_pkg::XLEN-12){instr[31]}}, instr[31:20]};
    decoded.illegal = 1'b0;
    case (instr[6:0])
      rv_isa_pkg::OP: begin
        if (funct7 == rv_isa_pkg::FUNCT7_MULDIV) begin
          decoded.unit    = backend_pkg::FU_MUL;
          decoded.illegal = funct3 != rv_isa_pkg::F3_MUL;
        end else if (funct7 == rv_isa_pkg::FUNCT7_ALT) begin
          decoded.illegal = funct3 != rv_isa_pkg::F3_ADD_SUB && funct3 != rv_isa_pkg::F3_SRL_SRA;
        end else begin
          decoded.illegal = funct7 != rv_isa_pkg::FUNCT7_BASE;
        end
      end
      rv_isa_pkg::OP_IMM: begin
        // Bit 30 only picks SRAI, ADDI keeps it as immediate
        decoded.alu_op  = alu_op_of(funct3, funct3 == rv_isa_pkg::F3_SRL_SRA && instr[30]);
        decoded.use_imm = 1'b1;
        decoded.rs2     = '0;
        if (funct3 == rv_isa_pkg::F3_SLL) decoded.illegal = instr[31:26] != 6'b000000;
        if (funct3 == rv_isa_pkg::F3_SRL_SRA) begin
          decoded.illegal = instr[31:26] != 6'b000000 && instr[31:26] != 6'b010000;
        end
      end
      rv_isa_pkg::LUI: begin
        decoded.alu_op  = backend_pkg::ALU_ADD;
        decoded.use_imm = 1'b1;
        decoded.rs1     = '0;
        decoded.rs2     = '0;
        decoded.imm     = {{(rv_isa_pkg::XLEN-32){instr[31]}}, instr[31:12], 12'b0};
      end
      default: decoded.illegal = 1'b1;
    endcase
    // No source reads for an illegal word
    if (decoded.illegal) begin
      decoded.unit = backend_pkg::FU_ALU;
      decoded.rs1  = '0;
      decoded.rs2  = '0;
    end
  end

  // Ready only from the first cycle after reset
  assign fetch_ready_o = init_done_q && (!de_valid_q || de_ready_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      init_done_q <= 1'b0;
      de_valid_q  <= 1'b0;
    end else begin
      init_done_q <= 1'b1;
      if (fetch_valid_i && fetch_ready_o) begin
        de_valid_q <= 1'b1;
      end else if (de_ready_i) begin
        de_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fetch_valid_i && fetch_ready_o) begin
      de_instr_q <= decoded;
    end
  end

  assign de_valid_o = de_valid_q;
  assign de_instr_o = de_instr_q;
  // Register file reads from the held source fields
  assign rs1_addr_o = de_instr_q.rs1;
  assign rs2_addr_o = de_instr_q.rs2;

  a_hold_until_issue: assert property (@(posedge clk_i) disable iff (!rst_ni)
    de_valid_o && !de_ready_i |=> de_valid_o && $stable(de_instr_o));

endmodule

//--- source/reg_file.sv
`timescale 1ns/100ps

module reg_file (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] raddr_a_i,
  output logic [rv_isa_pkg::XLEN-1:0]       rdata_a_o,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] raddr_b_i,
  output logic [rv_isa_pkg::XLEN-1:0]       rdata_b_o,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic [rv_isa_pkg::XLEN-1:0]       wdata_i,
  input  logic                              we_i
);

  // x0 has no storage
  logic [rv_isa_pkg::XLEN-1:0] regs_q [1:31];

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

  always_ff @(posedge clk_i) begin
    if (we_i && waddr_i != '0) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Writeback filters x0 before it gets here
  a_no_x0_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
    we_i |-> waddr_i != '0);

endmodule

//--- source/issue_control.sv
`timescale 1ns/100ps

module issue_control (
  input  logic                        de_valid_i,
  input  backend_pkg::decoded_t       de_instr_i,
  output logic                        de_ready_o,
  input  logic [rv_isa_pkg::XLEN-1:0] rs1_data_i,
  input  logic [rv_isa_pkg::XLEN-1:0] rs2_data_i,
  input  backend_pkg::stage_status_t  ex1_status_i,
  input  backend_pkg::stage_status_t  ex2_status_i,
  input  logic                        ex1_ready_i,
  input  logic                        mul_ready_i,
  output logic                        issue_o,
  output logic [rv_isa_pkg::XLEN-1:0] operand_a_o,
  output logic [rv_isa_pkg::XLEN-1:0] operand_b_o
);

  typedef struct packed {
    logic                        hazard;
    logic [rv_isa_pkg::XLEN-1:0] data;
  } operand_t;

  operand_t src_a;
  operand_t src_b;
  logic     data_hazard;
  logic     struct_hazard;

  // Youngest producer wins, EX1 before EX2 before the register file
  function automatic operand_t resolve(input logic [rv_isa_pkg::REG_ADDR_W-1:0] src,
                                       input logic [rv_isa_pkg::XLEN-1:0] rf_data,
                                       input backend_pkg::stage_status_t ex1,
                                       input backend_pkg::stage_status_t ex2);
    resolve = '{hazard: 1'b0, data: rf_data};
    if (src != '0 && ex1.pending && ex1.rd == src) begin
      resolve = '{hazard: !ex1.data_valid, data: ex1.data};
    end else if (src != '0 && ex2.pending && ex2.rd == src) begin
      resolve = '{hazard: !ex2.data_valid, data: ex2.data};
    end
  endfunction

  always_comb begin
    src_a = resolve(de_instr_i.rs1, rs1_data_i, ex1_status_i, ex2_status_i);
    src_b = resolve(de_instr_i.rs2, rs2_data_i, ex1_status_i, ex2_status_i);
  end

  assign data_hazard   = src_a.hazard || src_b.hazard;
  assign struct_hazard = !ex1_ready_i ||
                         (de_instr_i.unit == backend_pkg::FU_MUL && !mul_ready_i);

  assign operand_a_o = src_a.data;
  assign operand_b_o = de_instr_i.use_imm ? de_instr_i.imm : src_b.data;

  assign de_ready_o = !data_hazard && !struct_hazard;
  assign issue_o    = de_valid_i && de_ready_o;

endmodule

//--- source/int_alu.sv
`timescale 1ns/100ps

module int_alu (
  input  backend_pkg::alu_op_e        op_i,
  input  logic [rv_isa_pkg::XLEN-1:0] a_i,
  input  logic [rv_isa_pkg::XLEN-1:0] b_i,
  output logic [rv_isa_pkg::XLEN-1:0] result_o
);

  logic [5:0] shamt;

  assign shamt = b_i[5:0];

  always_comb begin
    case (op_i)
      backend_pkg::ALU_ADD:  result_o = a_i + b_i;
      backend_pkg::ALU_SUB:  result_o = a_i - b_i;
      backend_pkg::ALU_AND:  result_o = a_i & b_i;
      backend_pkg::ALU_OR:   result_o = a_i | b_i;
      backend_pkg::ALU_XOR:  result_o = a_i ^ b_i;
      backend_pkg::ALU_SLL:  result_o = a_i << shamt;
      backend_pkg::ALU_SRL:  result_o = a_i >> shamt;
      backend_pkg::ALU_SRA:  result_o = $signed(a_i) >>> shamt;
      // Set-less-than results are zero extended
      backend_pkg::ALU_SLT:  result_o = {{(rv_isa_pkg::XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
      backend_pkg::ALU_SLTU: result_o = {{(rv_isa_pkg::XLEN-1){1'b0}}, a_i < b_i};
      default:               result_o = '0;
    endcase
  end

endmodule

//--- source/iterative_multiplier.sv
`timescale 1ns/100ps

module iterative_multiplier #(
  parameter int MulBitsPerCycle = 8
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        req_valid_i,
  output logic                        req_ready_o,
  input  logic [rv_isa_pkg::XLEN-1:0] a_i,
  input  logic [rv_isa_pkg::XLEN-1:0] b_i,
  output logic                        resp_valid_o,
  output logic [rv_isa_pkg::XLEN-1:0] resp_value_o
);

  localparam int Iterations = rv_isa_pkg::XLEN / MulBitsPerCycle;
  localparam int CountW     = $clog2(Iterations + 1);

  logic                        busy_q;
  logic [CountW-1:0]           count_q;
  logic                        done;
  logic [rv_isa_pkg::XLEN-1:0] a_q;
  logic [rv_isa_pkg::XLEN-1:0] b_q;
  logic [rv_isa_pkg::XLEN-1:0] acc_q;
  logic [rv_isa_pkg::XLEN-1:0] partial;

  assign done         = count_q == CountW'(Iterations);
  assign req_ready_o  = !busy_q;
  assign resp_valid_o = busy_q && done;
  assign resp_value_o = acc_q;

  // Low slice of b times the shifted multiplicand, upper bits drop out
  assign partial = a_q * b_q[MulBitsPerCycle-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q  <= 1'b0;
      count_q <= '0;
    end else if (req_valid_i && req_ready_o) begin
      busy_q  <= 1'b1;
      count_q <= '0;
    end else if (busy_q) begin
      if (done) begin
        busy_q <= 1'b0;
      end else begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      a_q   <= a_i;
      b_q   <= b_i;
      acc_q <= '0;
    end else if (busy_q && !done) begin
      acc_q <= acc_q + partial;
      a_q   <= a_q << MulBitsPerCycle;
      b_q   <= b_q >> MulBitsPerCycle;
    end
  end

  a_no_req_when_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    busy_q |-> !req_valid_i);

endmodule

//--- source/exec_pipeline.sv
`timescale 1ns/100ps

module exec_pipeline (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              issue_i,
  input  backend_pkg::decoded_t             issue_instr_i,
  input  logic [rv_isa_pkg::XLEN-1:0]       operand_a_i,
  input  logic [rv_isa_pkg::XLEN-1:0]       operand_b_i,
  input  logic                              mul_valid_i,
  input  logic [rv_isa_pkg::XLEN-1:0]       mul_data_i,
  output logic                              ex1_ready_o,
  output backend_pkg::stage_status_t        ex1_status_o,
  output backend_pkg::stage_status_t        ex2_status_o,
  output logic [rv_isa_pkg::REG_ADDR_W-1:0] rf_waddr_o,
  output logic [rv_isa_pkg::XLEN-1:0]       rf_wdata_o,
  output logic                              rf_we_o,
  output backend_pkg::commit_t              commit_o
);

  logic [rv_isa_pkg::XLEN-1:0] alu_result;

  logic                              ex1_pending_q, ex2_pending_q;
  backend_pkg::func_unit_e           ex1_unit_q, ex2_unit_q;
  logic [rv_isa_pkg::REG_ADDR_W-1:0] ex1_rd_q, ex2_rd_q;
  logic [rv_isa_pkg::XLEN-1:0]       ex1_pc_q, ex2_pc_q;
  logic                              ex1_illegal_q, ex2_illegal_q;
  logic [rv_isa_pkg::XLEN-1:0]       ex1_alu_q, ex2_alu_q;

  logic                        ex1_data_valid, ex2_data_valid;
  logic [rv_isa_pkg::XLEN-1:0] ex1_data, ex2_data;
  logic                        ex2_ready;

  int_alu u_alu (
    .op_i     (issue_instr_i.alu_op),
    .a_i      (operand_a_i),
    .b_i      (operand_b_i),
    .result_o (alu_result)
  );

  //////////////////////////////
  // Result selection
  //////////////////////////////

  always_comb begin
    if (ex1_unit_q == backend_pkg::FU_MUL) begin
      // A response belongs to EX2 while EX2 still waits on it
      ex1_data_valid = mul_valid_i && ex2_unit_q != backend_pkg::FU_MUL;
      ex1_data       = mul_data_i;
    end else begin
      ex1_data_valid = 1'b1;
      ex1_data       = ex1_alu_q;
    end
    ex2_data_valid = ex2_unit_q == backend_pkg::FU_MUL ? mul_valid_i : 1'b1;
    ex2_data       = ex2_unit_q == backend_pkg::FU_MUL ? mul_data_i : ex2_alu_q;
  end

  assign ex2_ready   = !ex2_pending_q || ex2_data_valid;
  assign ex1_ready_o = !ex1_pending_q || ex2_ready;

  //////////////////////////////
  // EX1 and EX2 registers
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ex1_pending_q <= 1'b0;
      ex1_unit_q    <= backend_pkg::FU_ALU;
      ex2_pending_q <= 1'b0;
      ex2_unit_q    <= backend_pkg::FU_ALU;
    end else begin
      if (issue_i) begin
        ex1_pending_q <= 1'b1;
        ex1_unit_q    <= issue_instr_i.unit;
      end else if (ex2_ready) begin
        ex1_pending_q <= 1'b0;
        ex1_unit_q    <= backend_pkg::FU_ALU;
      end else if (ex1_data_valid) begin
        // Result already in hand, hold it in the ALU slot
        ex1_unit_q <= backend_pkg::FU_ALU;
      end
      if (ex1_pending_q && ex2_ready) begin
        ex2_pending_q <= 1'b1;
        ex2_unit_q    <= ex1_data_valid ? backend_pkg::FU_ALU : ex1_unit_q;
      end else if (ex2_data_valid) begin
        ex2_pending_q <= 1'b0;
        ex2_unit_q    <= backend_pkg::FU_ALU;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_i) begin
      ex1_rd_q      <= issue_instr_i.rd;
      ex1_pc_q      <= issue_instr_i.pc;
      ex1_illegal_q <= issue_instr_i.illegal;
      ex1_alu_q     <= alu_result;
    end else if (ex1_data_valid) begin
      ex1_alu_q <= ex1_data;
    end
    if (ex1_pending_q && ex2_ready) begin
      ex2_rd_q      <= ex1_rd_q;
      ex2_pc_q      <= ex1_pc_q;
      ex2_illegal_q <= ex1_illegal_q;
      ex2_alu_q     <= ex1_data;
    end
  end

  // An illegal instruction produces nothing to forward
  assign ex1_status_o = '{pending: ex1_pending_q, rd: ex1_illegal_q ? '0 : ex1_rd_q,
                          data_valid: ex1_data_valid, data: ex1_data};
  assign ex2_status_o = '{pending: ex2_pending_q, rd: ex2_illegal_q ? '0 : ex2_rd_q,
                          data_valid: ex2_data_valid, data: ex2_data};

  //////////////////////////////
  // Writeback and commit
  //////////////////////////////

  assign commit_o = '{valid: ex2_pending_q && ex2_data_valid, pc: ex2_pc_q, rd: ex2_rd_q,
                      data: ex2_data, illegal: ex2_illegal_q};

  assign rf_we_o    = commit_o.valid && ex2_rd_q != '0 && !ex2_illegal_q;
  assign rf_waddr_o = ex2_rd_q;
  assign rf_wdata_o = ex2_data;

  a_mul_resp_has_owner: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mul_valid_i |-> (ex1_pending_q && ex1_unit_q == backend_pkg::FU_MUL) ||
                    (ex2_pending_q && ex2_unit_q == backend_pkg::FU_MUL));

endmodule

//--- source/backend_top.sv
`timescale 1ns/100ps

module backend_top #(
  parameter int MulBitsPerCycle = 8
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 fetch_valid_i,
  output logic                 fetch_ready_o,
  input  backend_pkg::fetch_t  fetch_instr_i,
  output backend_pkg::commit_t commit_o
);

  logic                              de_valid, de_ready;
  backend_pkg::decoded_t             de_instr;
  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1_addr, rs2_addr;
  logic [rv_isa_pkg::XLEN-1:0]       rs1_data, rs2_data;
  logic                              issue;
  logic [rv_isa_pkg::XLEN-1:0]       operand_a, operand_b;
  logic                              mul_ready, mul_valid;
  logic [rv_isa_pkg::XLEN-1:0]       mul_data;
  logic                              ex1_ready;
  backend_pkg::stage_status_t        ex1_status, ex2_status;
  logic [rv_isa_pkg::REG_ADDR_W-1:0] rf_waddr;
  logic [rv_isa_pkg::XLEN-1:0]       rf_wdata;
  logic                              rf_we;

  decode_stage u_decode (
    .clk_i, .rst_ni, .fetch_valid_i, .fetch_ready_o, .fetch_instr_i,
    .de_ready_i (de_ready),
    .de_valid_o (de_valid),
    .de_instr_o (de_instr),
    .rs1_addr_o (rs1_addr),
    .rs2_addr_o (rs2_addr)
  );

  reg_file u_reg_file (
    .clk_i, .rst_ni,
    .raddr_a_i (rs1_addr), .rdata_a_o (rs1_data),
    .raddr_b_i (rs2_addr), .rdata_b_o (rs2_data),
    .waddr_i   (rf_waddr), .wdata_i   (rf_wdata), .we_i (rf_we)
  );

  issue_control u_issue (
    .de_valid_i   (de_valid),     .de_instr_i   (de_instr),   .de_ready_o  (de_ready),
    .rs1_data_i   (rs1_data),     .rs2_data_i   (rs2_data),
    .ex1_status_i (ex1_status),   .ex2_status_i (ex2_status),
    .ex1_ready_i  (ex1_ready),    .mul_ready_i  (mul_ready),
    .issue_o      (issue),        .operand_a_o  (operand_a),  .operand_b_o (operand_b)
  );

  iterative_multiplier #(
    .MulBitsPerCycle (MulBitsPerCycle)
  ) u_mul (
    .clk_i, .rst_ni,
    .req_valid_i  (issue && de_instr.unit == backend_pkg::FU_MUL),
    .req_ready_o  (mul_ready),
    .a_i          (operand_a),    .b_i          (operand_b),
    .resp_valid_o (mul_valid),    .resp_value_o (mul_data)
  );

  exec_pipeline u_exec (
    .clk_i, .rst_ni,
    .issue_i      (issue),        .issue_instr_i (de_instr),
    .operand_a_i  (operand_a),    .operand_b_i   (operand_b),
    .mul_valid_i  (mul_valid),    .mul_data_i    (mul_data),
    .ex1_ready_o  (ex1_ready),
    .ex1_status_o (ex1_status),   .ex2_status_o  (ex2_status),
    .rf_waddr_o   (rf_waddr),     .rf_wdata_o    (rf_wdata),   .rf_we_o (rf_we),
    .commit_o
  );

endmodule

//--- tests/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    repeat (16) @(posedge clk_o);
    #2 rst_no = 1'b1;
  end

  always #10 clk_o = ~clk_o;

endmodule

//--- tests/backend_tb.sv
`timescale 1ns/100ps

module backend_tb;

  localparam int MaxInstr = 128;
  localparam int Limit    = MaxInstr * (rv_isa_pkg::XLEN + 8) + 100;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 fetch_valid_i;
  logic                 fetch_ready_o;
  backend_pkg::fetch_t  fetch_instr_i;
  backend_pkg::commit_t commit_o;

  logic [63:0] regs [0:31];
  logic [63:0] exp_pc [0:MaxInstr-1];
  logic [4:0]  exp_rd [0:MaxInstr-1];
  logic [63:0] exp_data [0:MaxInstr-1];
  logic        exp_ill [0:MaxInstr-1];
  int          fetch_n;
  int          commit_n;
  int          errors;
  int          tests;
  int          cycles;
  logic        timed;
  logic        dep_wait;
  logic [63:0] dep_pc;
  string       test_name;

  tb_clock_gen u_clk (.clk_o(clk_i), .rst_no(rst_ni));

  backend_top #(.MulBitsPerCycle(8)) dut_i (
    .clk_i, .rst_ni, .fetch_valid_i, .fetch_ready_o, .fetch_instr_i, .commit_o
  );

  function automatic logic [31:0] r_type(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3,
                                         int rd);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'(rv_isa_pkg::OP)};
  endfunction

  function automatic logic [31:0] i_type(logic [11:0] imm, int rs1, logic [2:0] f3, int rd);
    return {imm, rs1[4:0], f3, rd[4:0], 7'(rv_isa_pkg::OP_IMM)};
  endfunction

  function automatic logic [31:0] lui(logic [19:0] imm, int rd);
    return {imm, rd[4:0], 7'(rv_isa_pkg::LUI)};
  endfunction

  // ALU rules of the base ISA for a funct3 and the alternate bit
  function automatic logic [63:0] alu_rule(logic [2:0] f3, logic alt, logic [63:0] a,
                                           logic [63:0] b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[5:0];
      3'd2:    return {63'b0, $signed(a) < $signed(b)};
      3'd3:    return {63'b0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? 64'($signed(a) >>> b[5:0]) : a >> b[5:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  // Reference result of one instruction word, illegal set for unsupported encodings
  function automatic logic [63:0] reference(logic [31:0] w, output logic ill);
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [63:0] a;
    logic [63:0] imm;
    f3  = w[14:12];
    f7  = w[31:25];
    a   = regs[w[19:15]];
    imm = {{52{w[31]}}, w[31:20]};
    ill = 1'b0;
    case (w[6:0])
      7'(rv_isa_pkg::OP): begin
        if (f7 == 7'h01) begin
          ill = f3 != 3'd0;
          return a * regs[w[24:20]];
        end
        ill = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
        return alu_rule(f3, w[30], a, regs[w[24:20]]);
      end
      7'(rv_isa_pkg::OP_IMM): begin
        if (f3 == 3'd1) ill = w[31:26] != 6'h00;
        if (f3 == 3'd5) ill = w[31:26] != 6'h00 && w[31:26] != 6'h10;
        return alu_rule(f3, f3 == 3'd5 && w[30], a, imm);
      end
      7'(rv_isa_pkg::LUI): return {{32{w[31]}}, w[31:12], 12'b0};
      default: begin
        ill = 1'b1;
        return '0;
      end
    endcase
  endfunction

  // Offers one word and returns just after the transfer edge
  task automatic send(logic [31:0] w);
    logic        ill;
    logic [63:0] data;
    fetch_valid_i = 1'b1;
    fetch_instr_i = '{pc: 64'h1000 + 64'(fetch_n) * 4, instr_word: w};
    while (!fetch_ready_o) begin
      @(posedge clk_i);
      #2;
    end
    data = reference(w, ill);
    exp_pc[fetch_n]   = fetch_instr_i.pc;
    exp_rd[fetch_n]   = w[11:7];
    exp_data[fetch_n] = data;
    exp_ill[fetch_n]  = ill;
    if (!ill && w[11:7] != 5'd0) regs[w[11:7]] = data;
    fetch_n++;
    @(posedge clk_i);
    #2;
  endtask

  task automatic idle(int n);
    fetch_valid_i = 1'b0;
    repeat (n) begin
      @(posedge clk_i);
      #2;
    end
  endtask

  task automatic finish_test();
    idle(0);
    while (commit_n != fetch_n) begin
      @(posedge clk_i);
      #2;
    end
    tests++;
    $display("test %-10s done, %0d instructions, %0d errors so far", test_name, fetch_n, errors);
  endtask

  task automatic report(string field, logic [63:0] exp_v, logic [63:0] act_v);
    $display("** Error [%s] commit %s: expected %h, actual %h", test_name, field, exp_v, act_v);
    errors++;
  endtask

  always @(posedge clk_i) begin
    if (commit_o.valid) commit_n <= commit_n + 1;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles == Limit) begin
      $display("Timeout after %0d cycles, %0d of %0d commits seen", cycles, commit_n, fetch_n);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  a_reset_quiet: assert property (@(posedge clk_i) !rst_ni |-> !commit_o.valid && !fetch_ready_o)
    else begin
      $display("Reset: commit valid or fetch ready high during reset");
      errors++;
    end

  a_ready_after_reset: assert property (@(posedge clk_i) $rose(rst_ni) |->
    !commit_o.valid && !fetch_ready_o ##1 fetch_ready_o)
    else begin
      $display("Reset: fetch ready not low then high after reset release");
      errors++;
    end

  a_commit_owed: assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_o.valid |-> commit_n < fetch_n)
    else begin
      $display("[%s] commit with no fetched instruction outstanding", test_name);
      errors++;
    end

  a_commit_pc: assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_o.valid |-> commit_o.pc == exp_pc[commit_n])
    else report("pc", exp_pc[$sampled(commit_n)], $sampled(commit_o.pc));

  a_commit_rd: assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_o.valid |-> commit_o.rd == exp_rd[commit_n])
    else report("rd", 64'(exp_rd[$sampled(commit_n)]), 64'($sampled(commit_o.rd)));

  a_commit_illegal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_o.valid |-> commit_o.illegal == exp_ill[commit_n])
    else report("illegal", 64'(exp_ill[$sampled(commit_n)]), 64'($sampled(commit_o.illegal)));

  a_commit_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_o.valid && !exp_ill[commit_n] |-> commit_o.data == exp_data[commit_n])
    else report("data", exp_data[$sampled(commit_n)], $sampled(commit_o.data));

  // Unstalled ALU work retires three edges after its transfer
  a_alu_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    timed && fetch_valid_i && fetch_ready_o |->
    ##3 commit_o.valid && commit_o.pc == $past(fetch_instr_i.pc, 3))
    else begin
      $display("[%s] ALU instruction did not commit three cycles after fetch", test_name);
      errors++;
    end

  // An instruction waiting on a MUL result keeps fetch closed until that MUL retires
  a_stall_blocks_fetch: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dep_wait && !(commit_o.valid && commit_o.pc == dep_pc) |-> !fetch_ready_o)
    else begin
      $display("[%s] fetch ready high while an instruction waits on a MUL", test_name);
      errors++;
    end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin
    int          r;
    logic [2:0]  f3;
    logic [11:0] imm;
    void'($urandom(32'h635ca227));
    fetch_valid_i = 1'b0;
    fetch_instr_i = '0;
    fetch_n = 0;
    commit_n = 0;
    errors = 0;
    tests = 0;
    cycles = 0;
    timed = 1'b0;
    dep_wait = 1'b0;
    dep_pc = '0;
    for (int i = 0; i < 32; i++) regs[i] = '0;

    test_name = "reset";
    wait (rst_ni);
    repeat (3) @(posedge clk_i);
    #2;
    finish_test();

    test_name = "alu";
    for (int i = 1; i < 16; i++) send(i_type(12'($urandom), 0, 3'd0, i));
    send(lui(20'hfedcb, 14));
    for (int i = 0; i < 8; i++) begin
      send(r_type(7'h00, $urandom_range(1, 15), $urandom_range(1, 15), 3'(i),
                  $urandom_range(1, 15)));
    end
    send(r_type(7'h20, 3, 14, 3'd0, 9));
    send(r_type(7'h20, 2, 14, 3'd5, 10));
    send(i_type(12'h403, 14, 3'd5, 11));
    send(i_type(12'h005, 14, 3'd1, 12));
    send(i_type(12'hf80, 13, 3'd2, 13));
    // Every immediate form once
    for (int i = 0; i < 8; i++) send(i_type(12'h02d, 14, 3'(i), 1 + i));
    finish_test();

    test_name = "chain";
    timed = 1'b1;
    for (int i = 0; i < 12; i++) begin
      send(r_type(7'h00, 1 + (i + 2) % 4, 1 + (i + 3) % 4, 3'($urandom_range(0, 7)),
                  1 + i % 4));
    end
    timed = 1'b0;
    finish_test();

    test_name = "mul";
    send(r_type(7'h01, 2, 1, 3'd0, 5));
    send(r_type(7'h01, 4, 3, 3'd0, 6));
    dep_pc = exp_pc[fetch_n - 1];
    send(r_type(7'h00, 6, 5, 3'd0, 7));
    dep_wait = 1'b1;
    send(r_type(7'h01, 1, 7, 3'd0, 8));
    dep_wait = 1'b0;
    send(r_type(7'h00, 5, 8, 3'd4, 9));
    finish_test();

    test_name = "illegal";
    send(32'h0000_3083);
    send(r_type(7'h01, 2, 1, 3'd1, 2));
    send(r_type(7'h20, 2, 1, 3'd4, 3));
    send(r_type(7'h00, 2, 1, 3'd0, 4));
    send(i_type(12'h005, 1, 3'd0, 0));
    send(r_type(7'h00, 3, 0, 3'd0, 5));
    finish_test();

    test_name = "random";
    for (int i = 0; i < 40; i++) begin
      r  = $urandom_range(0, 9);
      f3 = 3'($urandom);
      if (r < 4) begin
        send(r_type(f3 == 3'd0 || f3 == 3'd5 ? {1'b0, 1'($urandom), 5'b0} : 7'h00,
                    $urandom_range(0, 15), $urandom_range(0, 15), f3, $urandom_range(0, 15)));
      end else if (r < 7) begin
        imm = 12'($urandom);
        if (f3 == 3'd1) imm = {6'b0, imm[5:0]};
        if (f3 == 3'd5) imm = {1'b0, imm[10], 4'b0, imm[5:0]};
        send(i_type(imm, $urandom_range(0, 15), f3, $urandom_range(0, 15)));
      end else if (r < 8) begin
        send(lui(20'($urandom), $urandom_range(0, 15)));
      end else begin
        send(r_type(7'h01, $urandom_range(0, 15), $urandom_range(0, 15), 3'd0,
                    $urandom_range(0, 15)));
      end
      idle($urandom_range(0, 3));
    end
    finish_test();

    $display("Tests %0d, instructions %0d, commits %0d, errors %0d",
             tests, fetch_n, commit_n, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- project.f
source/rv_isa_pkg.sv
source/backend_pkg.sv
source/decode_stage.sv
source/reg_file.sv
source/issue_control.sv
source/int_alu.sv
source/iterative_multiplier.sv
source/exec_pipeline.sv
source/backend_top.sv
tests/tb_clock_gen.sv
tests/backend_tb.sv

//--- Makefile
SIM := obj_dir/Vbackend_tb

.PHONY: compile run clean

compile: $(SIM)

$(SIM): project.f source/*.sv tests/*.sv
	verilator --binary --assert --timing -f project.f --top-module backend_tb

# The output goes to the terminal and the search decides the status
run: compile
	./$(SIM) | tee /dev/stderr | grep -q "^PASS: all tests$$"

clean:
	rm -rf obj_dir
